/* include/learn_consts.svh */
`ifndef LEARN_CONSTS_SVH
`define LEARN_CONSTS_SVH

// ====================
// array geometry
// ====================
`define LRN_LANES        16
`define LRN_ROWS         7
`define LRN_LANE_BITS    4
`define LRN_ROW_BITS     3

// ====================
// data widths
// ====================
`define LRN_WBITS        8
// seven 8-bit weights fit without wrap
`define LRN_SUMBITS      12
`define LRN_DELTA_BITS   2
`define LRN_OP_BITS      2

// partial sums formed in the first adder stage
`define LRN_ACC_PARTS    3

// ====================
// flow control
// ====================
// host credits, also depth of both FIFOs
`define LRN_CMD_CREDITS  4
// sink credits held by the egress after reset
`define LRN_RESP_CREDITS 4

`endif

/* hdl/learn_pkg.sv */
`include "learn_consts.svh"

package learn_pkg;

    // ====================
    // scalar types
    // ====================
    typedef logic signed [`LRN_WBITS-1:0]   weight_t;
    typedef logic signed [`LRN_SUMBITS-1:0] sum_t;
    typedef logic [`LRN_LANE_BITS-1:0]      lane_t;
    typedef logic [`LRN_ROW_BITS-1:0]       row_t;
    // lane i delta sits in bits 2i+1:2i
    typedef logic [`LRN_DELTA_BITS*`LRN_LANES-1:0] delta_vec_t;
    typedef logic [`LRN_ROWS-1:0]           spike_t;

    typedef enum logic [`LRN_OP_BITS-1:0] {
        OP_SET   = 2'd0,
        OP_INC   = 2'd1,
        OP_READ  = 2'd2,
        OP_INFER = 2'd3
    } op_t;

    // ====================
    // bundles
    // ====================
    // data: SET weight in low byte, INC deltas, INFER mask in low bits
    typedef struct packed {
        op_t        op;
        lane_t      lane;
        row_t       row;
        delta_vec_t data;
    } cmd_t;

    typedef weight_t [`LRN_ROWS-1:0] row_vec_t;

    typedef struct packed {
        logic     valid;
        op_t      op;
        weight_t  old_weight;
        row_vec_t lane_row;
        spike_t   mask;
    } stage_t;

    typedef struct packed {
        op_t  op;
        sum_t value;
    } resp_t;

endpackage : learn_pkg

/* hdl/cmd_ingress.sv */
`timescale 1ns/1ps
`include "learn_consts.svh"

module cmd_ingress (
    input  logic            clk,
    input  logic            rstb,
    input  logic            cmd_valid,
    input  learn_pkg::cmd_t cmd,
    output logic            exec,
    output learn_pkg::cmd_t issue_cmd
);

    localparam int DEPTH = `LRN_CMD_CREDITS;
    localparam int AW    = $clog2(DEPTH);

    learn_pkg::cmd_t mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;

    logic            empty;
    logic            can_pop;
    logic            push;
    logic            pop_mem;
    learn_pkg::cmd_t head;

    assign empty = (count == '0);

    // one idle cycle after every issue
    assign can_pop = !exec && (!empty || cmd_valid);

    // empty FIFO hands the incoming command straight through
    assign head    = empty ? cmd : mem[rd_ptr];
    assign push    = cmd_valid && !(can_pop && empty);
    assign pop_mem = can_pop && !empty;

    // ====================
    // storage
    // ====================
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            exec   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_mem) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(push) - (AW+1)'(pop_mem);
            exec  <= can_pop;
        end
    end

    // ====================
    // issue register
    // ====================
    always_ff @(posedge clk) begin
        if (can_pop) begin
            issue_cmd <= head;
        end
    end

    // host sent more commands than it had credits for
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rstb)
        cmd_valid |-> (count != DEPTH)
    );

    a_exec_spaced: assert property (
        @(posedge clk) disable iff (!rstb)
        exec |=> !exec
    );

endmodule : cmd_ingress

/* hdl/weight_manager.sv */
`timescale 1ns/1ps
`include "learn_consts.svh"

module weight_manager (
    input  logic              clk,
    input  logic              rstb,
    input  logic              exec,
    input  learn_pkg::cmd_t   cmd,
    output learn_pkg::stage_t stage_out
);

    typedef enum logic {READY, HALT} mgr_state_t;

    mgr_state_t state;

    learn_pkg::weight_t  weights  [`LRN_LANES][`LRN_ROWS];
    learn_pkg::weight_t  next_row [`LRN_LANES];
    learn_pkg::row_vec_t sel_row;
    learn_pkg::weight_t  old_weight;
    learn_pkg::row_t     row_idx;

    logic row_ok;
    logic accept;
    logic wr_en;

    logic                st_valid;
    learn_pkg::op_t      st_op;
    learn_pkg::weight_t  st_old;
    learn_pkg::row_vec_t st_row;
    learn_pkg::spike_t   st_mask;

    // row 7 does not exist, treat as no-op with old value 0
    assign row_ok  = (cmd.row < `LRN_ROWS);
    assign row_idx = row_ok ? cmd.row : '0;
    assign accept  = exec && (state == READY);
    assign wr_en   = accept && row_ok && (cmd.op == learn_pkg::OP_SET ||
                                          cmd.op == learn_pkg::OP_INC);

    // ====================
    // readout
    // ====================
    always_comb begin
        for (int r = 0; r < `LRN_ROWS; r++) begin
            sel_row[r] = weights[cmd.lane][r];
        end
    end

    assign old_weight = row_ok ? weights[cmd.lane][row_idx] : '0;

    // ====================
    // update values
    // ====================
    always_comb begin
        for (int i = 0; i < `LRN_LANES; i++) begin
            if (cmd.op == learn_pkg::OP_INC) begin
                // wraps at 8 bits
                next_row[i] = weights[i][row_idx] +
                              $signed(cmd.data[`LRN_DELTA_BITS*i +: `LRN_DELTA_BITS]);
            end else if (i == int'(cmd.lane)) begin
                next_row[i] = learn_pkg::weight_t'(cmd.data[`LRN_WBITS-1:0]);
            end else begin
                next_row[i] = weights[i][row_idx];
            end
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state <= READY;
            for (int i = 0; i < `LRN_LANES; i++) begin
                for (int r = 0; r < `LRN_ROWS; r++) begin
                    weights[i][r] <= '0;
                end
            end
        end else begin
            case (state)
                READY: if (exec) state <= HALT;
                HALT:  if (!exec) state <= READY;
                default: state <= READY;
            endcase
            if (wr_en) begin
                for (int i = 0; i < `LRN_LANES; i++) begin
                    weights[i][row_idx] <= next_row[i];
                end
            end
        end
    end

    // ====================
    // stage register
    // ====================
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            st_valid <= 1'b0;
        end else begin
            st_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            st_op   <= cmd.op;
            st_old  <= old_weight;
            st_row  <= sel_row;
            st_mask <= cmd.data[`LRN_ROWS-1:0];
        end
    end

    assign stage_out = '{valid: st_valid, op: st_op, old_weight: st_old,
                         lane_row: st_row, mask: st_mask};

    // ingress pacing keeps exec away from HALT
    a_no_exec_in_halt: assert property (
        @(posedge clk) disable iff (!rstb)
        (state == HALT) |-> !exec
    );

endmodule : weight_manager

/* hdl/lane_accumulator.sv */
`timescale 1ns/1ps
`include "learn_consts.svh"

module lane_accumulator (
    input  logic              clk,
    input  logic              rstb,
    input  learn_pkg::stage_t stage_in,
    output logic              resp_valid_out,
    output learn_pkg::resp_t  resp_out
);

    localparam int PARTS = `LRN_ACC_PARTS;
    localparam int GROUP = (`LRN_ROWS + PARTS - 1) / PARTS;

    learn_pkg::sum_t    part_d [PARTS];
    learn_pkg::sum_t    part_q [PARTS];
    learn_pkg::sum_t    total;

    logic               s1_valid;
    learn_pkg::op_t     s1_op;
    learn_pkg::weight_t s1_old;

    // ====================
    // stage one
    // ====================
    // rows 0-2, 3-5, 6
    always_comb begin
        for (int p = 0; p < PARTS; p++) begin
            part_d[p] = '0;
        end
        for (int r = 0; r < `LRN_ROWS; r++) begin
            if (stage_in.mask[r]) begin
                part_d[r / GROUP] = part_d[r / GROUP] + stage_in.lane_row[r];
            end
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= stage_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_in.valid) begin
            s1_op  <= stage_in.op;
            s1_old <= stage_in.old_weight;
            part_q <= part_d;
        end
    end

    // ====================
    // stage two
    // ====================
    always_comb begin
        total = '0;
        for (int p = 0; p < PARTS; p++) begin
            total = total + part_q[p];
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            resp_valid_out <= 1'b0;
        end else begin
            resp_valid_out <= s1_valid;
        end
    end

    // non-infer ops report the old weight, sign extended
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            resp_out.op    <= s1_op;
            resp_out.value <= (s1_op == learn_pkg::OP_INFER) ? total
                                                             : learn_pkg::sum_t'(s1_old);
        end
    end

endmodule : lane_accumulator

/* hdl/resp_egress.sv */
`timescale 1ns/1ps
`include "learn_consts.svh"

module resp_egress (
    input  logic             clk,
    input  logic             rstb,
    input  logic             in_valid,
    input  learn_pkg::resp_t resp_in,
    input  logic             resp_credit,
    output logic             resp_valid,
    output learn_pkg::resp_t resp
);

    localparam int DEPTH = `LRN_CMD_CREDITS;
    localparam int AW    = $clog2(DEPTH);
    localparam int CRW   = $clog2(`LRN_RESP_CREDITS) + 1;

    learn_pkg::resp_t mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic [CRW-1:0]   credits;
    logic             send;

    // head goes out whenever a sink credit is held
    assign send       = (count != '0) && (credits != '0);
    assign resp_valid = send;
    assign resp       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= resp_in;
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRW'(`LRN_RESP_CREDITS);
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count + (AW+1)'(in_valid) - (AW+1)'(send);
            credits <= credits + CRW'(resp_credit) - CRW'(send);
        end
    end

    // ====================
    // checks
    // ====================
    // host credit limit should keep this FIFO from filling
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rstb)
        in_valid |-> (count != DEPTH)
    );

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rstb)
        credits <= CRW'(`LRN_RESP_CREDITS)
    );

endmodule : resp_egress

/* hdl/learn_engine_top.sv */
`timescale 1ns/1ps
`include "learn_consts.svh"

module learn_engine_top (
    input  logic             clk,
    input  logic             rstb,
    input  logic             cmd_valid,
    input  learn_pkg::cmd_t  cmd,
    input  logic             resp_credit,
    output logic             resp_valid,
    output learn_pkg::resp_t resp
);

    logic              exec;
    learn_pkg::cmd_t   issue_cmd;
    learn_pkg::stage_t stage;
    logic              acc_valid;
    learn_pkg::resp_t  acc_resp;

    // ====================
    // pipeline
    // ====================
    cmd_ingress u_ingress (
        .clk       (clk),
        .rstb      (rstb),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .exec      (exec),
        .issue_cmd (issue_cmd)
    );

    weight_manager u_weights (
        .clk       (clk),
        .rstb      (rstb),
        .exec      (exec),
        .cmd       (issue_cmd),
        .stage_out (stage)
    );

    lane_accumulator u_accum (
        .clk            (clk),
        .rstb           (rstb),
        .stage_in       (stage),
        .resp_valid_out (acc_valid),
        .resp_out       (acc_resp)
    );

    resp_egress u_egress (
        .clk         (clk),
        .rstb        (rstb),
        .in_valid    (acc_valid),
        .resp_in     (acc_resp),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule : learn_engine_top

/* tb/tb_learn_engine.sv */
`timescale 1ns/1ps
`include "learn_consts.svh"

module tb_learn_engine;

    localparam int SEED        = 32'hca9290f2;
    localparam int RANDOM_CMDS = 200;
    // reset reads, set/read, increment, infer, backpressure, random
    localparam int NUM_CMDS    = 5 + 8 + 20 + 14 + 8 + RANDOM_CMDS;
    localparam int TIMEOUT     = NUM_CMDS * 12 + 200;

    localparam int SINK_FREE   = 0;
    localparam int SINK_HOLD   = 1;
    localparam int SINK_RANDOM = 2;

    logic             clk;
    logic             rstb;
    logic             cmd_valid;
    learn_pkg::cmd_t  cmd;
    logic             resp_credit;
    logic             resp_valid;
    learn_pkg::resp_t resp;

    int model_w [`LRN_LANES][`LRN_ROWS];
    learn_pkg::op_t exp_ops [$];
    int exp_vals [$];

    int host_credits;
    int owed_credits;
    int resp_count;
    int sink_mode;
    int cycle_count;

    learn_engine_top dut (
        .clk         (clk),
        .rstb        (rstb),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

    always #10 clk = ~clk;

    // ====================
    // run control
    // ====================
    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout: no finish after %0d cycles", TIMEOUT);
            abort_run();
        end
    end

    task automatic check_value(input int got, input int exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ====================
    // reference model
    // ====================
    function automatic int wrap_weight(input int value);
        learn_pkg::weight_t w;
        w = learn_pkg::weight_t'(value);
        return int'(w);
    endfunction

    // signed 2-bit delta of one lane
    function automatic int delta_of(input logic [31:0] data, input int lane);
        int d;
        d = data[2*lane +: 2];
        if (d > 1) begin
            d = d - 4;
        end
        return d;
    endfunction

    // ====================
    // host and sink side
    // ====================
    task automatic step_cycle(input logic valid, input learn_pkg::cmd_t c);
        learn_pkg::sum_t got_val;
        @(negedge clk);
        if (resp_valid) begin
            if (exp_ops.size() == 0) begin
                $display("response at %0t ns with no command outstanding", $time);
                abort_run();
            end
            got_val = resp.value;
            check_value(int'(resp.op), int'(exp_ops[0]),
                        $sformatf("response %0d op", resp_count));
            check_value(int'(got_val), exp_vals[0],
                        $sformatf("response %0d value", resp_count));
            void'(exp_ops.pop_front());
            void'(exp_vals.pop_front());
            host_credits++;
            owed_credits++;
            resp_count++;
        end
        if (owed_credits > 0 && (sink_mode == SINK_FREE ||
            (sink_mode == SINK_RANDOM && $urandom_range(1, 0) == 1))) begin
            resp_credit  = 1'b1;
            owed_credits--;
        end else begin
            resp_credit = 1'b0;
        end
        cmd_valid = valid;
        cmd       = c;
    endtask

    task automatic idle_cycle();
        step_cycle(1'b0, '0);
    endtask

    // caller makes sure a host credit is held
    task automatic issue_now(input learn_pkg::op_t op, input int lane, input int row,
                             input logic [31:0] data);
        learn_pkg::cmd_t c;
        int value;
        c.op   = op;
        c.lane = learn_pkg::lane_t'(lane);
        c.row  = learn_pkg::row_t'(row);
        c.data = data;
        if (op == learn_pkg::OP_INFER) begin
            value = 0;
            for (int r = 0; r < `LRN_ROWS; r++) begin
                if (data[r]) begin
                    value += model_w[lane][r];
                end
            end
        end else begin
            value = model_w[lane][row];
        end
        case (op)
            learn_pkg::OP_SET: model_w[lane][row] = wrap_weight(int'($signed(data[7:0])));
            learn_pkg::OP_INC: begin
                for (int i = 0; i < `LRN_LANES; i++) begin
                    model_w[i][row] = wrap_weight(model_w[i][row] + delta_of(data, i));
                end
            end
            default: ;
        endcase
        exp_ops.push_back(op);
        exp_vals.push_back(value);
        host_credits--;
        step_cycle(1'b1, c);
    endtask

    task automatic send_cmd(input learn_pkg::op_t op, input int lane, input int row,
                            input logic [31:0] data);
        while (host_credits == 0) begin
            idle_cycle();
        end
        issue_now(op, lane, row, data);
    endtask

    task automatic wait_idle();
        while (exp_ops.size() != 0 || owed_credits != 0) begin
            idle_cycle();
        end
    endtask

    // ====================
    // tests
    // ====================
    task automatic test_reset_reads();
        send_cmd(learn_pkg::OP_READ, 0, 0, '0);
        send_cmd(learn_pkg::OP_READ, 15, 6, '0);
        send_cmd(learn_pkg::OP_READ, 7, 3, '0);
        send_cmd(learn_pkg::OP_READ, 3, 5, '0);
        send_cmd(learn_pkg::OP_READ, 12, 1, '0);
        wait_idle();
    endtask

    task automatic test_set_read();
        int lanes [4] = '{2, 9, 15, 2};
        int rows [4] = '{4, 0, 6, 4};
        logic [7:0] vals [4] = '{8'h5a, 8'h9c, 8'h80, 8'h7f};
        for (int k = 0; k < 4; k++) begin
            send_cmd(learn_pkg::OP_SET, lanes[k], rows[k], {24'h0, vals[k]});
            send_cmd(learn_pkg::OP_READ, lanes[k], rows[k], '0);
        end
        wait_idle();
    endtask

    task automatic test_increment();
        send_cmd(learn_pkg::OP_SET, 0, 2, 32'h7f);
        send_cmd(learn_pkg::OP_SET, 1, 2, 32'h80);
        // lane 0 +1 and lane 1 -1 wrap around
        send_cmd(learn_pkg::OP_INC, 0, 2, 32'h9c3b_e17d);
        send_cmd(learn_pkg::OP_INC, 4, 2, 32'hfedc_ba98);
        for (int i = 0; i < `LRN_LANES; i++) begin
            send_cmd(learn_pkg::OP_READ, i, 2, '0);
        end
        wait_idle();
    endtask

    task automatic test_infer();
        logic [7:0] vals [`LRN_ROWS] = '{8'd100, 8'h80, 8'h7f, 8'hce, 8'd3, 8'd90, 8'hf9};
        logic [6:0] masks [6] = '{7'h00, 7'h7f, 7'h01, 7'h2a, 7'h55, 7'h40};
        for (int r = 0; r < `LRN_ROWS; r++) begin
            send_cmd(learn_pkg::OP_SET, 5, r, {24'h0, vals[r]});
        end
        for (int k = 0; k < 6; k++) begin
            send_cmd(learn_pkg::OP_INFER, 5, 0, {25'h0, masks[k]});
        end
        send_cmd(learn_pkg::OP_INFER, 2, 3, 32'h7f);
        wait_idle();
    endtask

    task automatic test_backpressure();
        int sent;
        int start_count;
        sink_mode   = SINK_HOLD;
        sent        = 0;
        start_count = resp_count;
        repeat (40) begin
            if (host_credits > 0) begin
                if (sent % 2 == 0) begin
                    issue_now(learn_pkg::OP_SET, sent / 2, 3, $urandom());
                end else begin
                    issue_now(learn_pkg::OP_READ, sent / 2, 3, '0);
                end
                sent++;
            end else begin
                idle_cycle();
            end
        end
        check_value(resp_count - start_count, `LRN_RESP_CREDITS, "responses while held");
        check_value(sent, `LRN_CMD_CREDITS + `LRN_RESP_CREDITS, "commands while held");
        check_value(host_credits, 0, "host credits while held");
        sink_mode = SINK_FREE;
        wait_idle();
    endtask

    task automatic test_random_mix();
        learn_pkg::op_t op;
        sink_mode = SINK_RANDOM;
        repeat (RANDOM_CMDS) begin
            op = learn_pkg::op_t'($urandom_range(3, 0));
            send_cmd(op, $urandom_range(`LRN_LANES - 1, 0), $urandom_range(`LRN_ROWS - 1, 0),
                     $urandom());
        end
        sink_mode = SINK_FREE;
        wait_idle();
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        rstb         = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        resp_credit  = 1'b0;
        host_credits = `LRN_CMD_CREDITS;
        owed_credits = 0;
        resp_count   = 0;
        sink_mode    = SINK_FREE;
        cycle_count  = 0;
        for (int i = 0; i < `LRN_LANES; i++) begin
            for (int r = 0; r < `LRN_ROWS; r++) begin
                model_w[i][r] = 0;
            end
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstb = 1'b1;

        test_reset_reads();
        test_set_read();
        test_increment();
        test_infer();
        test_backpressure();
        test_random_mix();

        $display("sim passed");
        $finish;
    end

endmodule : tb_learn_engine

/* flist.f */
+incdir+include
hdl/learn_pkg.sv
hdl/cmd_ingress.sv
hdl/weight_manager.sv
hdl/lane_accumulator.sv
hdl/resp_egress.sv
hdl/learn_engine_top.sv
tb/tb_learn_engine.sv
